// File: verilog/i2c_pkg.sv
package i2c_pkg;

    // Device address byte, then two payload bytes
    localparam int I2C_FRAME_BYTES = 3;
    localparam int I2C_FRAME_W     = I2C_FRAME_BYTES * 8;

    // Eight data slots plus one acknowledge slot per byte
    localparam int I2C_BYTE_SLOTS  = 9;
    localparam int I2C_SLOTS       = I2C_FRAME_BYTES * I2C_BYTE_SLOTS;  // 27

    // MSB goes out first
    typedef logic [I2C_FRAME_W-1:0] i2c_frame_t;

    // Frame must stay stable while req is high
    typedef struct packed {
        logic       req;
        i2c_frame_t frame;
    } i2c_req_t;

    // nack only meaningful while ack is high
    typedef struct packed {
        logic ack;
        logic nack;
    } i2c_rsp_t;

endpackage

// File: verilog/codec_pkg.sv
package codec_pkg;

    localparam int REG_ADDR_W = 7;
    localparam int DATA_W     = 9;
    localparam int VOL_W      = 7;

    typedef logic [REG_ADDR_W-1:0] codec_reg_t;
    typedef logic [DATA_W-1:0]     codec_data_t;
    typedef logic [VOL_W-1:0]      codec_vol_t;

    localparam logic [7:0] CODEC_DEV_ADDR    = 8'h34;  // Write address with CSB low
    localparam codec_reg_t CODEC_REG_LHP_OUT = 7'd2;

    typedef struct packed {
        codec_reg_t  reg_addr;
        codec_data_t data;
    } init_entry_t;

    localparam int INIT_LEN = 7;

    // Entry 0 goes out first
    localparam init_entry_t INIT_TABLE [INIT_LEN] = '{
        '{reg_addr: 7'h0f, data: 9'h000},  // Reset
        '{reg_addr: 7'h04, data: 9'h015},  // Analogue path with DAC select and mic boost
        '{reg_addr: 7'h05, data: 9'h000},  // Digital path
        '{reg_addr: 7'h06, data: 9'h000},  // No block powered down
        '{reg_addr: 7'h07, data: 9'h042},  // Master mode I2S at 16 bit
        '{reg_addr: 7'h08, data: 9'h019},  // Sampling
        '{reg_addr: 7'h09, data: 9'h001}   // Active
    };

endpackage

// File: verilog/i2c_write_master.sv
`timescale 1ns/1ps

module i2c_write_master (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  i2c_pkg::i2c_req_t i_req,
    output i2c_pkg::i2c_rsp_t o_rsp,
    input  logic              i_sda,
    output logic              o_scl,
    output logic              o_sda,
    output logic              o_sda_oen
);
    import i2c_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_START, S_LOW, S_HIGH, S_STOP, S_ACK} state_t;
    typedef logic [$clog2(I2C_SLOTS)-1:0] slot_t;

    localparam slot_t LAST_SLOT = slot_t'(I2C_SLOTS - 1);

    state_t     state_r, state_w;
    slot_t      slot_r, slot_w;
    logic       scl_r, scl_w;
    logic       sda_r, sda_w;
    logic       oen_r, oen_w;
    logic       nack_r, nack_w;
    logic       load_slot;
    logic       shift_en;
    i2c_frame_t shift_r;

    // Last slot of every byte belongs to the slave
    function automatic logic is_ack_slot(input slot_t s);
        return (s % I2C_BYTE_SLOTS) == (I2C_BYTE_SLOTS - 1);
    endfunction

    assign o_scl     = scl_r;
    assign o_sda     = sda_r;
    assign o_sda_oen = oen_r;
    assign o_rsp.ack  = (state_r == S_ACK);
    assign o_rsp.nack = nack_r;

    always_comb begin
        state_w   = state_r;
        slot_w    = slot_r;
        scl_w     = scl_r;
        sda_w     = sda_r;
        oen_w     = oen_r;
        nack_w    = nack_r;
        load_slot = 1'b0;
        case (state_r)
            S_IDLE: begin
                if (i_req.req) begin
                    sda_w   = 1'b0;  // Start condition as SDA falls under high SCL
                    nack_w  = 1'b0;
                    state_w = S_START;
                end
            end
            S_START: begin
                load_slot = 1'b1;
                slot_w    = '0;
                state_w   = S_LOW;
            end
            S_LOW: begin
                scl_w   = 1'b1;
                state_w = S_HIGH;
            end
            S_HIGH: begin
                if (is_ack_slot(slot_r))
                    nack_w = nack_r | i_sda;  // Released line still high
                if (slot_r == LAST_SLOT) begin
                    scl_w   = 1'b0;
                    sda_w   = 1'b0;
                    oen_w   = 1'b1;
                    state_w = S_STOP;
                end
                else begin
                    load_slot = 1'b1;
                    slot_w    = slot_r + 1'b1;
                    state_w   = S_LOW;
                end
            end
            S_STOP: begin
                if (!scl_r) begin
                    scl_w = 1'b1;
                end
                else begin
                    sda_w   = 1'b1;  // Stop condition as SDA rises under high SCL
                    state_w = S_ACK;
                end
            end
            S_ACK: begin
                if (!i_req.req)
                    state_w = S_IDLE;
            end
            default: state_w = S_IDLE;
        endcase

        // Put the next slot on the bus as SCL falls
        if (load_slot) begin
            scl_w = 1'b0;
            oen_w = !is_ack_slot(slot_w);
            if (!is_ack_slot(slot_w))
                sda_w = shift_r[I2C_FRAME_W-1];
        end
    end

    assign shift_en = load_slot && !is_ack_slot(slot_w);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r <= S_IDLE;
            slot_r  <= '0;
            scl_r   <= 1'b1;
            sda_r   <= 1'b1;
            oen_r   <= 1'b1;
            nack_r  <= 1'b0;
        end
        else begin
            state_r <= state_w;
            slot_r  <= slot_w;
            scl_r   <= scl_w;
            sda_r   <= sda_w;
            oen_r   <= oen_w;
            nack_r  <= nack_w;
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == S_IDLE)
            shift_r <= i_req.frame;  // Requester holds it from here on
        else if (shift_en)
            shift_r <= shift_r << 1;
    end

endmodule

// File: verilog/i2c_arbiter.sv
`timescale 1ns/1ps

module i2c_arbiter (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  i2c_pkg::i2c_req_t i_init_req,
    output i2c_pkg::i2c_rsp_t o_init_rsp,
    input  i2c_pkg::i2c_req_t i_vol_req,
    output i2c_pkg::i2c_rsp_t o_vol_rsp,
    output i2c_pkg::i2c_req_t o_mst_req,
    input  i2c_pkg::i2c_rsp_t i_mst_rsp
);

    typedef enum logic [1:0] {G_NONE, G_INIT, G_VOL} grant_t;

    grant_t grant_r, grant_w;

    always_comb begin
        grant_w = grant_r;
        case (grant_r)
            G_NONE: begin
                if (i_init_req.req)
                    grant_w = G_INIT;  // Initializer wins a tie
                else if (i_vol_req.req)
                    grant_w = G_VOL;
            end
            // Hold until the handshake has returned to zero
            G_INIT: begin
                if (!i_init_req.req && !i_mst_rsp.ack)
                    grant_w = G_NONE;
            end
            G_VOL: begin
                if (!i_vol_req.req && !i_mst_rsp.ack)
                    grant_w = G_NONE;
            end
            default: grant_w = G_NONE;
        endcase
    end

    // Loser keeps seeing ack low and waits
    always_comb begin
        o_mst_req  = '0;
        o_init_rsp = '0;
        o_vol_rsp  = '0;
        case (grant_r)
            G_INIT: begin
                o_mst_req  = i_init_req;
                o_init_rsp = i_mst_rsp;
            end
            G_VOL: begin
                o_mst_req = i_vol_req;
                o_vol_rsp = i_mst_rsp;
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n)
            grant_r <= G_NONE;
        else
            grant_r <= grant_w;
    end

endmodule

// File: verilog/codec_initializer.sv
`timescale 1ns/1ps

module codec_initializer (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_start,
    output i2c_pkg::i2c_req_t o_req,
    input  i2c_pkg::i2c_rsp_t i_rsp,
    output logic              o_init_done
);
    import codec_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_RELEASE, S_DONE} state_t;

    state_t                      state_r, state_w;
    logic [$clog2(INIT_LEN)-1:0] idx_r, idx_w;

    assign o_req.req   = (state_r == S_REQ);
    assign o_req.frame = {CODEC_DEV_ADDR, INIT_TABLE[idx_r].reg_addr, INIT_TABLE[idx_r].data};
    assign o_init_done = (state_r == S_DONE);

    always_comb begin
        state_w = state_r;
        idx_w   = idx_r;
        case (state_r)
            S_IDLE: begin
                if (i_start) begin
                    idx_w   = '0;
                    state_w = S_REQ;
                end
            end
            S_REQ: begin
                if (i_rsp.ack)
                    state_w = S_RELEASE;  // nack is left to the top level
            end
            S_RELEASE: begin
                // Wait for ack low before the next entry
                if (!i_rsp.ack) begin
                    if (idx_r == INIT_LEN - 1) begin
                        state_w = S_DONE;
                    end
                    else begin
                        idx_w   = idx_r + 1'b1;
                        state_w = S_REQ;
                    end
                end
            end
            S_DONE: ;  // Stays here until reset
            default: state_w = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r <= S_IDLE;
            idx_r   <= '0;
        end
        else begin
            state_r <= state_w;
            idx_r   <= idx_w;
        end
    end

endmodule

// File: verilog/codec_volume_writer.sv
`timescale 1ns/1ps

module codec_volume_writer (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_vol_valid,
    input  codec_pkg::codec_vol_t i_vol,
    output logic                  o_vol_busy,
    output i2c_pkg::i2c_req_t     o_req,
    input  i2c_pkg::i2c_rsp_t     i_rsp
);
    import codec_pkg::*;

    typedef enum logic [1:0] {V_IDLE, V_REQ, V_RELEASE} state_t;

    state_t     state_r, state_w;
    codec_vol_t vol_r;

    assign o_vol_busy  = (state_r != V_IDLE);
    assign o_req.req   = (state_r == V_REQ);
    // No zero cross, no both-channel update
    assign o_req.frame = {CODEC_DEV_ADDR, CODEC_REG_LHP_OUT, {(DATA_W - VOL_W){1'b0}}, vol_r};

    always_comb begin
        state_w = state_r;
        case (state_r)
            V_IDLE:    if (i_vol_valid) state_w = V_REQ;
            V_REQ:     if (i_rsp.ack) state_w = V_RELEASE;
            V_RELEASE: if (!i_rsp.ack) state_w = V_IDLE;  // Busy ends with ack
            default:   state_w = V_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n)
            state_r <= V_IDLE;
        else
            state_r <= state_w;
    end

    // Requests while busy are dropped
    always_ff @(posedge i_clk) begin
        if (state_r == V_IDLE && i_vol_valid)
            vol_r <= i_vol;
    end

endmodule

// File: verilog/codec_cfg_top.sv
`timescale 1ns/1ps

module codec_cfg_top (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  logic                  i_vol_valid,
    input  codec_pkg::codec_vol_t i_vol,
    output logic                  o_vol_busy,
    output logic                  o_init_done,
    output logic                  o_nack_error,
    input  logic                  i_sda,
    output logic                  o_scl,
    output logic                  o_sda,
    output logic                  o_sda_oen
);
    import i2c_pkg::*;

    i2c_req_t init_req, vol_req, mst_req;
    i2c_rsp_t init_rsp, vol_rsp, mst_rsp;
    logic     nack_error_r;

    codec_initializer u_codec_initializer (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .o_req       (init_req),
        .i_rsp       (init_rsp),
        .o_init_done (o_init_done)
    );

    codec_volume_writer u_codec_volume_writer (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_vol_valid (i_vol_valid),
        .i_vol       (i_vol),
        .o_vol_busy  (o_vol_busy),
        .o_req       (vol_req),
        .i_rsp       (vol_rsp)
    );

    i2c_arbiter u_i2c_arbiter (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_init_req (init_req),
        .o_init_rsp (init_rsp),
        .i_vol_req  (vol_req),
        .o_vol_rsp  (vol_rsp),
        .o_mst_req  (mst_req),
        .i_mst_rsp  (mst_rsp)
    );

    i2c_write_master u_i2c_write_master (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_req     (mst_req),
        .o_rsp     (mst_rsp),
        .i_sda     (i_sda),
        .o_scl     (o_scl),
        .o_sda     (o_sda),
        .o_sda_oen (o_sda_oen)
    );

    // Sticky until reset, whichever peer owned the frame
    always_ff @(posedge i_clk) begin
        if (!i_rst_n)
            nack_error_r <= 1'b0;
        else if (mst_rsp.ack && mst_rsp.nack)
            nack_error_r <= 1'b1;
    end

    assign o_nack_error = nack_error_r;

endmodule

// File: sim/tb_codec_cfg.sv
`timescale 1ns/1ps

module tb_codec_cfg;
    import codec_pkg::*;

    localparam int          CLK_HALF       = 5;
    localparam int          RESET_CYCLES   = 2;
    localparam int          IDLE_CYCLES    = 10;
    localparam int          FRAME_BITS     = 24;
    localparam int          SLOT_COUNT     = 27;
    localparam int          VOL_RUNS       = 3;
    localparam int          NACK_FRAME     = 3;   // Counted from 1 after reset
    localparam int          FRAME_CYCLES   = 80;
    localparam int          FRAME_TOTAL    = 2 * INIT_LEN + 1 + VOL_RUNS;
    localparam int          TIMEOUT_CYCLES = FRAME_TOTAL * FRAME_CYCLES + 200;
    localparam logic [31:0] LFSR_SEED      = 32'ha0e40269;
    localparam logic [31:0] LFSR_TAPS      = 32'hd0000001;

    // Decoded frame with the address byte first
    typedef struct packed {
        logic [7:0]  dev;
        codec_reg_t  reg_addr;
        codec_data_t data;
    } frame_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start;
    logic        vol_valid;
    codec_vol_t  vol;
    logic        vol_busy;
    logic        init_done;
    logic        nack_error;
    logic        scl;
    logic        sda;
    logic        sda_oen;
    wire         bus_sda;
    wire         ack_level;

    logic        scl_q;
    logic        sda_q;
    logic        in_frame;
    logic        nack_seen;
    logic        idle_phase;
    int          rise_cnt;
    int          frame_cnt;
    int          stop_cnt;
    int          nack_frame = 0;
    frame_t      data_bits;
    frame_t      frame_q[$];
    logic [31:0] lfsr_state = LFSR_SEED;

    always #CLK_HALF clk = ~clk;

    codec_cfg_top u_codec_cfg_top (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_start      (start),
        .i_vol_valid  (vol_valid),
        .i_vol        (vol),
        .o_vol_busy   (vol_busy),
        .o_init_done  (init_done),
        .o_nack_error (nack_error),
        .i_sda        (bus_sda),
        .o_scl        (scl),
        .o_sda        (sda),
        .o_sda_oen    (sda_oen)
    );

    // Slave acks low except in the selected frame
    assign ack_level = (nack_frame != 0) && (frame_cnt == nack_frame);
    assign bus_sda   = sda_oen ? sda : ack_level;

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic value_error(input string what);
        $display("** Error @ %0t ns: %s", $time, what);
        abort_run();
    endtask

    function automatic logic releases_bus(input int slot);
        return (slot == 8) || (slot == 17) || (slot == 26);
    endfunction

    // Right-shift Galois form of x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic frame_t init_frame(input int idx);
        return '{dev: CODEC_DEV_ADDR, reg_addr: INIT_TABLE[idx].reg_addr,
                 data: INIT_TABLE[idx].data};
    endfunction

    function automatic frame_t vol_frame(input codec_vol_t v);
        return '{dev: CODEC_DEV_ADDR, reg_addr: CODEC_REG_LHP_OUT, data: {2'b00, v}};
    endfunction

    // Start, stop and data bits as seen on the bus
    always @(posedge clk) begin
        if (!rst_n) begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            in_frame  <= 1'b0;
            nack_seen <= 1'b0;
            rise_cnt  <= 0;
            frame_cnt <= 0;
            stop_cnt  <= 0;
        end
        else begin
            scl_q <= scl;
            sda_q <= bus_sda;
            if (scl && scl_q && sda_q && !bus_sda) begin
                in_frame  <= 1'b1;
                rise_cnt  <= 0;
                frame_cnt <= frame_cnt + 1;
            end
            else if (scl && scl_q && !sda_q && bus_sda && in_frame) begin
                in_frame <= 1'b0;
                stop_cnt <= stop_cnt + 1;
                frame_q.push_back(data_bits);
                if (nack_frame != 0 && frame_cnt == nack_frame)
                    nack_seen <= 1'b1;
            end
            else if (scl && !scl_q && in_frame) begin
                rise_cnt <= rise_cnt + 1;
                if (rise_cnt < SLOT_COUNT && sda_oen)
                    data_bits <= {data_bits[FRAME_BITS-2:0], bus_sda};
            end
        end
    end

    a_idle_bus: assert property (@(posedge clk) disable iff (!rst_n)
        idle_phase |-> (scl && sda && sda_oen && !init_done && !nack_error))
        else value_error("bus or status not idle before start");

    a_start_between_frames: assert property (@(posedge clk) disable iff (!rst_n)
        (scl && scl_q && sda_q && !bus_sda) |-> !in_frame)
        else value_error("SDA fell under high SCL inside a frame");

    // 27 slots plus the SCL rise that sets up the stop
    a_stop_after_slots: assert property (@(posedge clk) disable iff (!rst_n)
        (scl && scl_q && !sda_q && bus_sda) |-> (in_frame && rise_cnt == SLOT_COUNT + 1))
        else value_error($sformatf("SDA rose under high SCL after %0d SCL rises", rise_cnt));

    a_ack_slots: assert property (@(posedge clk) disable iff (!rst_n)
        (scl && !scl_q && in_frame) |-> (sda_oen == !releases_bus(rise_cnt)))
        else value_error($sformatf("wrong oen %0b on SCL rise %0d", sda_oen, rise_cnt));

    a_done_after_table: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(init_done) |-> (stop_cnt >= INIT_LEN))
        else value_error($sformatf("init done after only %0d stops", stop_cnt));

    a_done_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        $past(init_done) |-> init_done)
        else value_error("init done fell without reset");

    a_busy_at_once: assert property (@(posedge clk) disable iff (!rst_n)
        $past(vol_valid && !vol_busy) |-> vol_busy)
        else value_error("volume busy not raised after request");

    a_nack_after_frame: assert property (@(posedge clk) disable iff (!rst_n)
        nack_error |-> nack_seen)
        else value_error("nack error without a nacked frame");

    a_nack_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        $past(nack_error) |-> nack_error)
        else value_error("nack error fell without reset");

    task automatic apply_reset();
        rst_n      <= 1'b0;
        idle_phase <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start      <= 1'b1;
        idle_phase <= 1'b0;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // One LFSR step per volume bit
    task automatic draw_volume(output codec_vol_t v);
        for (int i = 0; i < $bits(codec_vol_t); i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v[i]       = lfsr_state[0];
        end
    endtask

    task automatic request_volume(input codec_vol_t v);
        @(posedge clk);
        vol_valid <= 1'b1;
        vol       <= v;
        @(posedge clk);
        vol_valid <= 1'b0;
    endtask

    task automatic pop_frame(output frame_t f);
        while (frame_q.size() == 0)
            @(posedge clk);
        f = frame_q.pop_front();
    endtask

    task automatic check_frame(input frame_t got, input frame_t exp, input string what);
        assert (got == exp)
        else value_error($sformatf("%s frame is %h, expected %h", what, got, exp));
    endtask

    initial begin
        frame_t     got;
        codec_vol_t v;
        int         init_idx;
        logic       vol_seen;
        start      <= 1'b0;
        vol_valid  <= 1'b0;
        vol        <= '0;
        apply_reset();
        repeat (IDLE_CYCLES) @(posedge clk);

        // Init table with a volume request in the middle
        pulse_start();
        while (!in_frame)
            @(posedge clk);
        draw_volume(v);
        request_volume(v);
        init_idx = 0;
        vol_seen = 1'b0;
        for (int k = 0; k < INIT_LEN + 1; k++) begin
            pop_frame(got);
            if (got.reg_addr == CODEC_REG_LHP_OUT) begin
                assert (!vol_seen && init_idx > 0)
                else value_error($sformatf("volume frame out of place at frame %0d", k));
                check_frame(got, vol_frame(v), "volume");
                vol_seen = 1'b1;
            end
            else begin
                assert (init_idx < INIT_LEN)
                else value_error("more init frames than table entries");
                check_frame(got, init_frame(init_idx), "init");
                init_idx++;
            end
        end
        while (!init_done || vol_busy)
            @(posedge clk);

        for (int n = 0; n < VOL_RUNS; n++) begin
            draw_volume(v);
            request_volume(v);
            pop_frame(got);
            check_frame(got, vol_frame(v), "volume");
            while (vol_busy)
                @(posedge clk);
        end

        // Second pass with one frame rejected by the slave
        apply_reset();
        nack_frame = NACK_FRAME;
        repeat (IDLE_CYCLES) @(posedge clk);
        pulse_start();
        for (int k = 0; k < INIT_LEN; k++) begin
            pop_frame(got);
            check_frame(got, init_frame(k), "init");
        end
        while (!init_done)
            @(posedge clk);
        assert (nack_error == 1'b1)
        else value_error("nack error low after a nacked frame");
        assert (frame_q.size() == 0)
        else value_error($sformatf("%0d unexpected frames left", frame_q.size()));
        $display("Simulation passed");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("The run timed out after %0d clock cycles", TIMEOUT_CYCLES);
        abort_run();
    end

endmodule

// File: codec_cfg.f
verilog/i2c_pkg.sv
verilog/codec_pkg.sv
verilog/i2c_write_master.sv
verilog/i2c_arbiter.sv
verilog/codec_initializer.sv
verilog/codec_volume_writer.sv
verilog/codec_cfg_top.sv
sim/tb_codec_cfg.sv

// File: Makefile
TOP := tb_codec_cfg

all: run

compile:
	verilator --binary --timing --assert -f codec_cfg.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > run.log 2>&1; cat run.log
	grep -q "Simulation passed" run.log

clean:
	rm -rf obj_dir run.log

.PHONY: all compile run clean
